/* verilog/afu_cfg.svh */
//////////////////////////////////////////////////
// Size settings for the host command controller
// Included by the package and by any module that
// needs a depth, a width or the credit reset value
//////////////////////////////////////////////////

`ifndef AFU_CFG_SVH
`define AFU_CFG_SVH

// Command address and host tag widths
`define AFU_ADDR_W 16
`define AFU_TAG_W 3

// Command queue depths per class
`define AFU_READ_CMD_DEPTH 4
`define AFU_WRITE_CMD_DEPTH 2

// Host credits
`define AFU_CREDITS_INIT 6
`define AFU_CREDIT_W 4

`endif

/* verilog/afu_pkg.sv */
//////////////////////////////////////////////////
// Shared types of the host command controller
// Modules take these by a wildcard import in the
// body, or by scoped names in their port lists
//////////////////////////////////////////////////

`include "afu_cfg.svh"

package afu_pkg;

	// Command address as seen by the host
	typedef logic [`AFU_ADDR_W-1:0] addr_t;

	// Host tag, one per outstanding command
	typedef logic [`AFU_TAG_W-1:0] tag_t;

	// Credit count
	typedef logic [`AFU_CREDIT_W-1:0] credit_t;

	// Response code from the host, not decoded here
	typedef logic [1:0] rsp_code_t;

	// Command class
	typedef enum logic {
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} cmd_op_t;

endpackage

/* verilog/tag_alloc_if.sv */
//////////////////////////////////////////////////
// Tag allocation between the issuer and the table
// The issuer raises alloc only while tag_ready is
// high, and the tag is taken at that clock edge
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "afu_cfg.svh"

interface tag_alloc_if;

	logic                   tag_ready;
	logic                   alloc;
	logic                   alloc_op;
	logic [`AFU_ADDR_W-1:0] alloc_addr;
	logic [`AFU_TAG_W-1:0]  alloc_tag;

	modport issuer (input tag_ready, input alloc_tag,
		output alloc, output alloc_op, output alloc_addr);

	modport tbl (output tag_ready, output alloc_tag,
		input alloc, input alloc_op, input alloc_addr);

endinterface

/* verilog/cmd_fifo.sv */
//////////////////////////////////////////////////
// Show-ahead FIFO for command addresses
// The head is always on data_out; a push shows
// there one cycle later
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cmd_fifo #(
	parameter int DEPTH = 4
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           push,
	input  afu_pkg::addr_t data_in,
	input  logic           pop,
	output afu_pkg::addr_t data_out,
	output logic           full,
	output logic           empty
);

	import afu_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	addr_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Storage
	always_ff @(posedge clock) begin
		if (push && !full) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// Pointers and fill level
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push && !full) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop && !empty) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push && !full) - CNT_W'(pop && !empty);
		end
	end

	assign data_out = mem[rd_ptr];
	assign full     = (count == CNT_W'(DEPTH));
	assign empty    = (count == '0);

	// Producer must watch full, issuer must watch empty
	a_no_push_full: assert property (@(posedge clock) disable iff (!rstn) full |-> !push);
	a_no_pop_empty: assert property (@(posedge clock) disable iff (!rstn) empty |-> !pop);

endmodule

/* verilog/cmd_issue.sv */
//////////////////////////////////////////////////
// Command issuer with host credit tracking
// Picks write ahead of read, takes a tag and a
// credit, and registers the host command
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "afu_cfg.svh"

module cmd_issue (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled,
	input  logic              write_empty,
	input  afu_pkg::addr_t    write_head,
	input  logic              read_empty,
	input  afu_pkg::addr_t    read_head,
	output logic              write_pop,
	output logic              read_pop,
	input  logic              rsp_valid,
	input  afu_pkg::credit_t  rsp_credits,
	tag_alloc_if.issuer       tags,
	output logic              cmd_valid,
	output afu_pkg::cmd_op_t  cmd_op,
	output afu_pkg::tag_t     cmd_tag,
	output afu_pkg::addr_t    cmd_addr
);

	import afu_pkg::*;

	credit_t credits;
	credit_t credits_back;
	logic    have_credit;
	logic    issue;
	logic    pick_write;
	cmd_op_t sel_op;
	addr_t   sel_addr;

	//////////////////////////////////////////////////
	// Selection
	//////////////////////////////////////////////////

	assign have_credit = (credits != '0);
	assign pick_write  = !write_empty;
	assign issue       = enabled && have_credit && tags.tag_ready
		&& (!write_empty || !read_empty);

	assign sel_op   = pick_write ? CMD_WRITE : CMD_READ;
	assign sel_addr = pick_write ? write_head : read_head;

	assign write_pop = issue && pick_write;
	assign read_pop  = issue && !pick_write;

	// Tag request toward the table
	assign tags.alloc      = issue;
	assign tags.alloc_op   = sel_op;
	assign tags.alloc_addr = sel_addr;

	//////////////////////////////////////////////////
	// Credits
	//////////////////////////////////////////////////

	// Returned credits count in the same cycle as the response
	assign credits_back = rsp_valid ? rsp_credits : '0;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= credit_t'(`AFU_CREDITS_INIT);
		end else begin
			credits <= credits - credit_t'(issue) + credits_back;
		end
	end

	//////////////////////////////////////////////////
	// Host command register
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			cmd_op   <= sel_op;
			cmd_tag  <= tags.alloc_tag;
			cmd_addr <= sel_addr;
		end
	end

	// Host returns no more than it was given
	a_credit_max: assert property (@(posedge clock) disable iff (!rstn)
		credits <= credit_t'(`AFU_CREDITS_INIT));

endmodule

/* verilog/tag_table.sv */
//////////////////////////////////////////////////
// Host tag table
// Hands out the lowest free tag, remembers class
// and address per tag, and routes each response
// to the done outputs of its class
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "afu_cfg.svh"

module tag_table (
	input  logic               clock,
	input  logic               rstn,
	tag_alloc_if.tbl           tags,
	input  logic               rsp_valid,
	input  afu_pkg::tag_t      rsp_tag,
	input  afu_pkg::rsp_code_t rsp_code,
	output logic               read_done_valid,
	output logic               write_done_valid,
	output afu_pkg::addr_t     done_addr,
	output afu_pkg::rsp_code_t done_code
);

	import afu_pkg::*;

	localparam int NTAGS = 1 << `AFU_TAG_W;

	logic [NTAGS-1:0] busy;
	cmd_op_t          op_mem   [NTAGS];
	addr_t            addr_mem [NTAGS];
	tag_t             free_tag;
	cmd_op_t          rsp_op;

	//////////////////////////////////////////////////
	// Free tag search
	//////////////////////////////////////////////////

	// Lowest index wins, so scan from the top down
	always_comb begin
		free_tag = '0;
		for (int i = NTAGS - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				free_tag = tag_t'(i);
			end
		end
	end

	assign tags.tag_ready = !(&busy);
	assign tags.alloc_tag = free_tag;

	//////////////////////////////////////////////////
	// Tag state
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= '0;
		end else begin
			if (rsp_valid) begin
				busy[rsp_tag] <= 1'b0;
			end
			if (tags.alloc) begin
				busy[free_tag] <= 1'b1;
			end
		end
	end

	// Class and address of each outstanding command
	always_ff @(posedge clock) begin
		if (tags.alloc) begin
			op_mem[free_tag]   <= cmd_op_t'(tags.alloc_op);
			addr_mem[free_tag] <= tags.alloc_addr;
		end
	end

	//////////////////////////////////////////////////
	// Response routing
	//////////////////////////////////////////////////

	assign rsp_op = op_mem[rsp_tag];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_done_valid  <= 1'b0;
			write_done_valid <= 1'b0;
		end else begin
			read_done_valid  <= rsp_valid && (rsp_op == CMD_READ);
			write_done_valid <= rsp_valid && (rsp_op == CMD_WRITE);
		end
	end

	always_ff @(posedge clock) begin
		if (rsp_valid) begin
			done_addr <= addr_mem[rsp_tag];
			done_code <= rsp_code;
		end
	end

	// Issuer side must respect tag_ready
	a_alloc_ready: assert property (@(posedge clock) disable iff (!rstn)
		tags.alloc |-> tags.tag_ready);

	// Host answers only tags it was given
	a_rsp_busy: assert property (@(posedge clock) disable iff (!rstn)
		rsp_valid |-> busy[rsp_tag]);

endmodule

/* verilog/afu_control.sv */
//////////////////////////////////////////////////
// Top of the host command and response path
// Queues read and write commands, issues them to
// the host under credit and tag limits, and
// reports host responses per class
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "afu_cfg.svh"

module afu_control (
	input  logic               clock,
	input  logic               rstn,
	input  logic               enabled_in,

	// Command producers
	input  logic               read_cmd_push,
	input  afu_pkg::addr_t     read_cmd_addr,
	input  logic               write_cmd_push,
	input  afu_pkg::addr_t     write_cmd_addr,
	output logic               read_cmd_full,
	output logic               write_cmd_full,

	// Host command
	output logic               cmd_valid,
	output afu_pkg::cmd_op_t   cmd_op,
	output afu_pkg::tag_t      cmd_tag,
	output afu_pkg::addr_t     cmd_addr,

	// Host response
	input  logic               rsp_valid,
	input  afu_pkg::tag_t      rsp_tag,
	input  afu_pkg::rsp_code_t rsp_code,
	input  afu_pkg::credit_t   rsp_credits,

	// Completions
	output logic               read_done_valid,
	output logic               write_done_valid,
	output afu_pkg::addr_t     done_addr,
	output afu_pkg::rsp_code_t done_code
);

	import afu_pkg::*;

	logic  enabled;
	logic  read_empty;
	logic  write_empty;
	logic  read_pop;
	logic  write_pop;
	addr_t read_head;
	addr_t write_head;

	tag_alloc_if tags ();

	//////////////////////////////////////////////////
	// Enable register
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	//////////////////////////////////////////////////
	// Command queues
	//////////////////////////////////////////////////

	cmd_fifo #(
		.DEPTH(`AFU_READ_CMD_DEPTH)
	) i_read_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (read_cmd_push),
		.data_in (read_cmd_addr),
		.pop     (read_pop),
		.data_out(read_head),
		.full    (read_cmd_full),
		.empty   (read_empty)
	);

	cmd_fifo #(
		.DEPTH(`AFU_WRITE_CMD_DEPTH)
	) i_write_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (write_cmd_push),
		.data_in (write_cmd_addr),
		.pop     (write_pop),
		.data_out(write_head),
		.full    (write_cmd_full),
		.empty   (write_empty)
	);

	//////////////////////////////////////////////////
	// Issue and tag tracking
	//////////////////////////////////////////////////

	cmd_issue i_issue (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.write_empty(write_empty),
		.write_head (write_head),
		.read_empty (read_empty),
		.read_head  (read_head),
		.write_pop  (write_pop),
		.read_pop   (read_pop),
		.rsp_valid  (rsp_valid),
		.rsp_credits(rsp_credits),
		.tags       (tags.issuer),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_tag    (cmd_tag),
		.cmd_addr   (cmd_addr)
	);

	tag_table i_tag_table (
		.clock           (clock),
		.rstn            (rstn),
		.tags            (tags.tbl),
		.rsp_valid       (rsp_valid),
		.rsp_tag         (rsp_tag),
		.rsp_code        (rsp_code),
		.read_done_valid (read_done_valid),
		.write_done_valid(write_done_valid),
		.done_addr       (done_addr),
		.done_code       (done_code)
	);

endmodule

/* tb/tb_afu_control.sv */
//////////////////////////////////////////////////
// Testbench for the host command controller
// Random pushes, a host model with credits and
// out-of-order responses, and per-cycle checks
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "afu_cfg.svh"

module tb_afu_control;

	import afu_pkg::*;

	localparam int NTAGS      = 1 << `AFU_TAG_W;
	localparam int RUN_CYCLES = 600;
	localparam int WAIT_LIMIT = 200;

	logic      clock;
	logic      rstn;
	logic      enabled_in;
	logic      read_cmd_push;
	addr_t     read_cmd_addr;
	logic      write_cmd_push;
	addr_t     write_cmd_addr;
	logic      read_cmd_full;
	logic      write_cmd_full;
	logic      cmd_valid;
	cmd_op_t   cmd_op;
	tag_t      cmd_tag;
	addr_t     cmd_addr;
	logic      rsp_valid;
	tag_t      rsp_tag;
	rsp_code_t rsp_code;
	credit_t   rsp_credits;
	logic      read_done_valid;
	logic      write_done_valid;
	addr_t     done_addr;
	rsp_code_t done_code;

	// Model state
	logic [31:0] rng;
	int          cyc;
	logic        en_d1;
	logic        en_d2;
	addr_t       read_q [$];
	addr_t       write_q [$];
	int          write_stamp [$];
	logic        out_busy [NTAGS];
	cmd_op_t     out_op [NTAGS];
	addr_t       out_addr [NTAGS];
	int          issued;
	int          answered;
	logic        exp_issue;
	logic        exp_write;
	logic        exp_done;
	cmd_op_t     exp_op;
	addr_t       exp_addr;
	rsp_code_t   exp_code;

	afu_control i_dut (
		.clock(clock), .rstn(rstn), .enabled_in(enabled_in),
		.read_cmd_push(read_cmd_push), .read_cmd_addr(read_cmd_addr),
		.write_cmd_push(write_cmd_push), .write_cmd_addr(write_cmd_addr),
		.read_cmd_full(read_cmd_full), .write_cmd_full(write_cmd_full),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_tag(cmd_tag), .cmd_addr(cmd_addr),
		.rsp_valid(rsp_valid), .rsp_tag(rsp_tag), .rsp_code(rsp_code),
		.rsp_credits(rsp_credits), .read_done_valid(read_done_valid),
		.write_done_valid(write_done_valid), .done_addr(done_addr), .done_code(done_code)
	);

	always #5 clock = ~clock;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int rand_below(input int n);
		rng = xorshift32(rng);
		return int'(rng % n);
	endfunction

	function automatic int count_outstanding();
		int n;
		n = 0;
		for (int i = 0; i < NTAGS; i++) begin
			if (out_busy[i]) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s at cycle %0d", what, cyc);
			stop_run();
		end
	endtask

	//////////////////////////////////////////////////
	// One cycle: check outputs, then clear pulses
	//////////////////////////////////////////////////

	task automatic tick();
		addr_t want;
		@(posedge clock);
		#1;
		cyc++;
		en_d2 = en_d1;
		en_d1 = enabled_in;
		// Done pulse one cycle after the response
		check_value("read_done_valid", 32'(exp_done && exp_op == CMD_READ), 32'(read_done_valid));
		check_value("write_done_valid", 32'(exp_done && exp_op == CMD_WRITE),
			32'(write_done_valid));
		if (exp_done) begin
			check_value("done_addr", 32'(exp_addr), 32'(done_addr));
			check_value("done_code", 32'(exp_code), 32'(done_code));
		end
		exp_done = 1'b0;
		check_value("cmd_valid", 32'(exp_issue), 32'(cmd_valid));
		if (cmd_valid) begin
			check_value("cmd_op", 32'(exp_write), 32'(cmd_op == CMD_WRITE));
			check_true(en_d2, "command issued while the block was disabled");
			check_true(!$isunknown(cmd_tag) && int'(cmd_tag) < NTAGS,
				"command tag unknown or out of range");
			check_true(!out_busy[cmd_tag], "command reused an outstanding tag");
			if (cmd_op == CMD_WRITE) begin
				check_true(write_q.size() > 0, "write issued with no write queued");
				want = write_q.pop_front();
				void'(write_stamp.pop_front());
				check_value("write_order", 32'(want), 32'(cmd_addr));
			end else begin
				check_true(read_q.size() > 0, "read issued with no read queued");
				check_true(!(write_stamp.size() > 0 && write_stamp[0] <= cyc - 2),
					"read issued while a write was waiting");
				want = read_q.pop_front();
				check_value("read_order", 32'(want), 32'(cmd_addr));
			end
			out_busy[cmd_tag] = 1'b1;
			out_op[cmd_tag]   = cmd_op;
			out_addr[cmd_tag] = cmd_addr;
			issued++;
		end
		check_true(count_outstanding() <= `AFU_CREDITS_INIT,
			"more commands outstanding than host credits");
		// Next cycle issues when enabled, a credit is left and a command waits
		exp_issue = en_d1 && (issued - answered) < `AFU_CREDITS_INIT
			&& (read_q.size() > 0 || write_q.size() > 0);
		exp_write = write_q.size() > 0;
		read_cmd_push  = 1'b0;
		write_cmd_push = 1'b0;
		rsp_valid      = 1'b0;
	endtask

	task automatic push_read(input addr_t a);
		read_cmd_push = 1'b1;
		read_cmd_addr = a;
		read_q.push_back(a);
	endtask

	task automatic push_write(input addr_t a);
		write_cmd_push = 1'b1;
		write_cmd_addr = a;
		write_q.push_back(a);
		write_stamp.push_back(cyc);
	endtask

	// Host answers one random outstanding tag with one credit
	task automatic respond_random();
		tag_t list [$];
		tag_t t;
		for (int i = 0; i < NTAGS; i++) begin
			if (out_busy[i]) begin
				list.push_back(tag_t'(i));
			end
		end
		if (list.size() > 0) begin
			t           = list[rand_below(list.size())];
			rsp_valid   = 1'b1;
			rsp_tag     = t;
			rsp_credits = credit_t'(1);
			rsp_code    = rsp_code_t'(rand_below(4));
			exp_done    = 1'b1;
			exp_op      = out_op[t];
			exp_addr    = out_addr[t];
			exp_code    = rsp_code;
			out_busy[t] = 1'b0;
			answered++;
		end
	endtask

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial begin
		int wait_cnt;
		int n_rd;
		int n_wr;
		clock = 1'b0;
		rstn = 1'b0;
		enabled_in = 1'b0;
		read_cmd_push = 1'b0;
		read_cmd_addr = '0;
		write_cmd_push = 1'b0;
		write_cmd_addr = '0;
		rsp_valid = 1'b0;
		rsp_tag = '0;
		rsp_code = '0;
		rsp_credits = '0;
		rng = 32'd78315;
		cyc = 0;
		en_d1 = 1'b0;
		en_d2 = 1'b0;
		issued = 0;
		answered = 0;
		exp_issue = 1'b0;
		exp_write = 1'b0;
		exp_done = 1'b0;
		for (int i = 0; i < NTAGS; i++) begin
			out_busy[i] = 1'b0;
		end
		repeat (2) @(posedge clock);
		#1;
		rstn = 1'b1;

		// Fill both queues while disabled, full must rise at depth
		n_rd = 0;
		n_wr = 0;
		wait_cnt = 0;
		while (!(read_cmd_full && write_cmd_full)) begin
			tick();
			check_value("read_full", 32'(n_rd == `AFU_READ_CMD_DEPTH), 32'(read_cmd_full));
			check_value("write_full", 32'(n_wr == `AFU_WRITE_CMD_DEPTH), 32'(write_cmd_full));
			if (n_rd < `AFU_READ_CMD_DEPTH) begin
				push_read(addr_t'(rand_below(65536)));
				n_rd++;
			end
			if (n_wr < `AFU_WRITE_CMD_DEPTH) begin
				push_write(addr_t'(rand_below(65536)));
				n_wr++;
			end
			wait_cnt++;
			check_true(wait_cnt < WAIT_LIMIT, "timeout while filling the command queues");
		end

		// Random traffic with short disable windows
		for (int c = 0; c < RUN_CYCLES; c++) begin
			tick();
			enabled_in = (rand_below(10) != 0);
			if (!read_cmd_full && rand_below(3) == 0) begin
				push_read(addr_t'(rand_below(65536)));
			end
			if (!write_cmd_full && rand_below(4) == 0) begin
				push_write(addr_t'(rand_below(65536)));
			end
			if (rand_below(3) == 0) begin
				respond_random();
			end
		end

		// Drain queues and outstanding commands
		enabled_in = 1'b1;
		wait_cnt = 0;
		while (read_q.size() > 0 || write_q.size() > 0 || count_outstanding() > 0) begin
			tick();
			respond_random();
			wait_cnt++;
			check_true(wait_cnt < WAIT_LIMIT, "timeout while draining commands");
		end
		tick();
		$display("TEST OK");
		$finish;
	end

endmodule

/* sim.f */
+incdir+verilog
verilog/afu_pkg.sv
verilog/tag_alloc_if.sv
verilog/cmd_fifo.sv
verilog/cmd_issue.sv
verilog/tag_table.sv
verilog/afu_control.sv
tb/tb_afu_control.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_afu_control
	@out="$$(./obj_dir/Vtb_afu_control)"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
